//--- mfPkg.sv
// ------------------------------------------------------------
// Shared types, constants and register map of the matched filter.
// Datapath widths are sized so that no stage can overflow.
// The Hilbert set is fixed at 7 taps in Q1.15.
// ------------------------------------------------------------
package mfPkg;

	// Real input samples and Q1.15 coefficient words.
	typedef logic signed [15:0] sampleT;
	typedef logic signed [15:0] coeffT;

	// Analytic samples keep a few guard bits above the input width.
	typedef logic signed [19:0] analyticT;

	// Full-precision complex convolution sum and its squared magnitude.
	typedef logic signed [39:0] firAccT;
	typedef logic [79:0] powerT;
	typedef logic [39:0] magnitudeT;

	// Bus address and output counter.
	typedef logic [7:0] regAddrT;
	typedef logic [15:0] countT;

	// The im field sits in the upper half, matching the bus word layout.
	typedef struct packed {
		coeffT im;
		coeffT re;
	} complexCoeffT;

	typedef struct packed {
		analyticT im;
		analyticT re;
	} analyticSampleT;

	typedef struct packed {
		firAccT im;
		firAccT re;
	} firOutT;

	// Hilbert transform taps, index 0 applied to the newest sample.
	localparam int HT_TAPS = 7;
	localparam int HT_SHIFT = 15;
	localparam coeffT HT_COEFFS [HT_TAPS] = '{
		-16'sd6954, 16'sd0, -16'sd20861, 16'sd0, 16'sd20861, 16'sd0, 16'sd6954
	};

	// Register map, byte offsets.
	localparam regAddrT REG_CONTROL = 8'h00;
	localparam regAddrT REG_STATUS = 8'h04;
	localparam regAddrT REG_COEFF_BASE = 8'h40;
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT = 1;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// States of the iterative square root.
	typedef enum logic [1:0] {
		IDLE,
		ITERATE,
		HOLD
	} sqrtStateT;

endpackage

//--- mfRegs.sv
// ------------------------------------------------------------
// AXI4-Lite slave, 8-bit address, 32-bit data, one transfer at a time.
// A write needs awvalid and wvalid together. Unmapped addresses
// answer SLVERR. The low two address bits are ignored.
// ------------------------------------------------------------
`timescale 1ns/1ps

module mfRegs #(
	parameter int MF_TAPS = 8
) (
	input  logic clock,
	input  logic reset,
	input  mfPkg::regAddrT awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  mfPkg::regAddrT araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic outputFire,
	output logic enable,
	output logic clearHistory,
	output mfPkg::complexCoeffT coeffs [MF_TAPS]
);
	import mfPkg::*;

	// Word addresses of the register map.
	localparam logic [5:0] CONTROL_WORD = REG_CONTROL[7:2];
	localparam logic [5:0] STATUS_WORD = REG_STATUS[7:2];
	localparam logic [5:0] COEFF_WORD = REG_COEFF_BASE[7:2];

	logic [5:0] writeWord;
	logic [5:0] readWord;
	logic writeStart;
	logic writeFire;
	logic readStart;
	logic readFire;
	logic [31:0] controlMerged;
	logic [31:0] readData;
	logic readOk;
	countT outputCount;

	// Replaces only the bytes whose strobe is set.
	function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
		input logic [31:0] newWord, input logic [3:0] strobe);
		logic [31:0] merged;
		merged = oldWord;
		for (int b = 0; b < 4; b++) begin
			if (strobe[b]) begin
				merged[8*b +: 8] = newWord[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// True when a word address falls inside the loaded table.
	function automatic logic isCoeffWord(input logic [5:0] word);
		return (word >= COEFF_WORD) && (int'(word) < int'(COEFF_WORD) + MF_TAPS);
	endfunction

	assign writeWord = awaddr[7:2];
	assign readWord = araddr[7:2];

	// Ready is raised for one cycle, so the transfer completes on the next edge.
	assign writeStart = awvalid && wvalid && !awready && !bvalid;
	assign writeFire = awready && awvalid && wvalid;
	assign readStart = arvalid && !arready && !rvalid;
	assign readFire = arready && arvalid;

	// Control bit 1 is a strobe, so it never reads back as set.
	assign controlMerged = mergeBytes(32'(enable), wdata, wstrb);

	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			enable <= 1'b0;
			clearHistory <= 1'b0;
			coeffs <= '{default: '0};
		end else begin
			awready <= writeStart;
			wready <= writeStart;
			clearHistory <= 1'b0;
			if (writeFire) begin
				bvalid <= 1'b1;
				bresp <= RESP_OKAY;
				if (writeWord == CONTROL_WORD) begin
					enable <= controlMerged[CTRL_ENABLE_BIT];
					clearHistory <= controlMerged[CTRL_CLEAR_BIT];
				end else if (isCoeffWord(writeWord)) begin
					for (int i = 0; i < MF_TAPS; i++) begin
						if (int'(writeWord) == int'(COEFF_WORD) + i) begin
							coeffs[i] <= mergeBytes(coeffs[i], wdata, wstrb);
						end
					end
				end else if (writeWord != STATUS_WORD) begin
					// The status word is read-only and quietly takes writes.
					bresp <= RESP_SLVERR;
				end
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Read decode, sampled on the address handshake.
	always_comb begin
		readData = '0;
		readOk = 1'b1;
		if (readWord == CONTROL_WORD) begin
			readData = 32'(enable);
		end else if (readWord == STATUS_WORD) begin
			readData = {outputCount, 15'b0, enable};
		end else if (isCoeffWord(readWord)) begin
			for (int i = 0; i < MF_TAPS; i++) begin
				if (int'(readWord) == int'(COEFF_WORD) + i) begin
					readData = coeffs[i];
				end
			end
		end else begin
			readOk = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= RESP_OKAY;
		end else begin
			arready <= readStart;
			if (readFire) begin
				rvalid <= 1'b1;
				rdata <= readData;
				rresp <= readOk ? RESP_OKAY : RESP_SLVERR;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Counts magnitudes taken by the sink. It wraps at 16 bits.
	always_ff @(posedge clock) begin
		if (reset) begin
			outputCount <= '0;
		end else if (outputFire) begin
			outputCount <= outputCount + 1'b1;
		end
	end

	// The master must hold an address until it is taken.
	assert property (@(posedge clock) disable iff (reset) awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");
	assert property (@(posedge clock) disable iff (reset) arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

endmodule

//--- hilbertFilter.sv
// ------------------------------------------------------------
// Fixed 7-tap Hilbert FIR. One output per accepted sample,
// registered one cycle after acceptance. The real part is the
// centre-tap sample, so it lags the input by three samples.
// ------------------------------------------------------------
`timescale 1ns/1ps

module hilbertFilter (
	input  logic clock,
	input  logic reset,
	input  logic clearHistory,
	input  mfPkg::sampleT sampleIn,
	input  logic sampleFire,
	output mfPkg::analyticSampleT analytic,
	output logic analyticValid
);
	import mfPkg::*;

	// Index 0 holds the newest sample.
	sampleT delayLine [HT_TAPS];
	sampleT nextLine [HT_TAPS];

	// 16x16 products over 7 taps fit easily in 36 bits.
	logic signed [35:0] quadSum;
	logic signed [35:0] quadShifted;

	// The line as it will be after the incoming sample is shifted in.
	// A clear in the same cycle drops the old history first.
	always_comb begin
		nextLine[0] = sampleIn;
		for (int k = 1; k < HT_TAPS; k++) begin
			nextLine[k] = clearHistory ? '0 : delayLine[k-1];
		end
	end

	// Quadrature output is the dot product with the fixed taps.
	always_comb begin
		quadSum = '0;
		for (int k = 0; k < HT_TAPS; k++) begin
			quadSum = quadSum + 36'(nextLine[k]) * 36'(HT_COEFFS[k]);
		end
		quadShifted = quadSum >>> HT_SHIFT;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			analyticValid <= 1'b0;
			delayLine <= '{default: '0};
		end else begin
			analyticValid <= sampleFire;
			if (sampleFire) begin
				delayLine <= nextLine;
			end else if (clearHistory) begin
				delayLine <= '{default: '0};
			end
		end
	end

	// The output pair only moves when a sample is accepted.
	always_ff @(posedge clock) begin
		if (sampleFire) begin
			analytic.re <= analyticT'(nextLine[HT_TAPS / 2]);
			analytic.im <= analyticT'(quadShifted);
		end
	end

endmodule

//--- complexFir.sv
// ------------------------------------------------------------
// Complex FIR over the last MF_TAPS analytic samples.
// Full precision, no rounding. Coefficients are read live, so a
// new table applies from the next sample on.
// ------------------------------------------------------------
`timescale 1ns/1ps

module complexFir #(
	parameter int MF_TAPS = 8
) (
	input  logic clock,
	input  logic reset,
	input  logic clearHistory,
	input  mfPkg::analyticSampleT analytic,
	input  logic analyticValid,
	input  mfPkg::complexCoeffT coeffs [MF_TAPS],
	output mfPkg::firOutT firOut,
	output logic firValid
);
	import mfPkg::*;

	// Tap 0 is the newest analytic sample.
	analyticSampleT delayLine [MF_TAPS];
	analyticSampleT nextLine [MF_TAPS];
	firAccT accRe;
	firAccT accIm;

	// Same shift-with-clear rule as the Hilbert stage.
	always_comb begin
		nextLine[0] = analytic;
		for (int k = 1; k < MF_TAPS; k++) begin
			nextLine[k] = clearHistory ? '0 : delayLine[k-1];
		end
	end

	// Complex multiply-accumulate across all taps.
	always_comb begin : firSum
		firAccT xRe;
		firAccT xIm;
		firAccT cRe;
		firAccT cIm;
		accRe = '0;
		accIm = '0;
		for (int k = 0; k < MF_TAPS; k++) begin
			// Sign-extend every operand to the accumulator width first.
			xRe = nextLine[k].re;
			xIm = nextLine[k].im;
			cRe = coeffs[k].re;
			cIm = coeffs[k].im;
			accRe = accRe + xRe * cRe - xIm * cIm;
			accIm = accIm + xRe * cIm + xIm * cRe;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			firValid <= 1'b0;
			delayLine <= '{default: '0};
		end else begin
			firValid <= analyticValid;
			if (analyticValid) begin
				delayLine <= nextLine;
			end else if (clearHistory) begin
				delayLine <= '{default: '0};
			end
		end
	end

	always_ff @(posedge clock) begin
		if (analyticValid) begin
			firOut.re <= accRe;
			firOut.im <= accIm;
		end
	end

	// Only one sample is ever in flight, so valids arrive at least two apart.
	assert property (@(posedge clock) disable iff (reset) analyticValid |=> !analyticValid)
		else $error("analyticValid high on consecutive cycles");

endmodule

//--- magnitudeSqrt.sv
// ------------------------------------------------------------
// Squared magnitude then a 40-step restoring square root.
// Takes a new FIR output only in IDLE. The result is the floor
// of the root and is held until the sink takes it.
// ------------------------------------------------------------
`timescale 1ns/1ps

module magnitudeSqrt (
	input  logic clock,
	input  logic reset,
	input  logic enable,
	input  mfPkg::firOutT firOut,
	input  logic firValid,
	input  logic pipeBusy,
	output logic sampleReady,
	output mfPkg::magnitudeT magnitude,
	output logic magnitudeValid,
	input  logic magnitudeReady,
	output logic outputFire
);
	import mfPkg::*;

	// One result bit per iteration.
	localparam int STEPS = $bits(magnitudeT);
	localparam int COUNT_W = $clog2(STEPS);
	localparam int POWER_W = $bits(powerT);
	// The partial remainder never exceeds twice the partial root.
	localparam int REM_W = STEPS + 2;
	// Enough room for (magnitude + 1) squared.
	localparam int SQ_W = POWER_W + 2;

	sqrtStateT state;
	logic [COUNT_W-1:0] stepCount;
	powerT power;
	powerT radicand;
	logic [REM_W-1:0] remainder;
	magnitudeT root;
	logic signed [POWER_W-1:0] reWide;
	logic signed [POWER_W-1:0] imWide;
	powerT squareSum;
	logic [REM_W+1:0] remShifted;
	logic [REM_W+1:0] trial;
	logic trialFits;

	always_comb begin
		reWide = firOut.re;
		imWide = firOut.im;
		squareSum = reWide * reWide + imWide * imWide;
	end

	// Bring down the next two radicand bits and try the root with a 1 appended.
	assign remShifted = {remainder, radicand[POWER_W-1 -: 2]};
	assign trial = {2'b00, root, 2'b01};
	assign trialFits = remShifted >= trial;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			stepCount <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (firValid) begin
						state <= ITERATE;
						stepCount <= COUNT_W'(STEPS - 1);
					end
				end
				ITERATE: begin
					if (stepCount == '0) begin
						state <= HOLD;
					end else begin
						stepCount <= stepCount - 1'b1;
					end
				end
				HOLD: begin
					if (magnitudeReady) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Root datapath. The power copy is kept for the range check.
	always_ff @(posedge clock) begin
		if (state == IDLE && firValid) begin
			power <= squareSum;
			radicand <= squareSum;
			remainder <= '0;
			root <= '0;
		end else if (state == ITERATE) begin
			remainder <= REM_W'(trialFits ? remShifted - trial : remShifted);
			root <= {root[STEPS-2:0], trialFits};
			radicand <= radicand << 2;
		end
	end

	assign magnitude = root;
	assign magnitudeValid = (state == HOLD);
	assign outputFire = magnitudeValid && magnitudeReady;

	// a new sample only when the whole chain is empty
	assign sampleReady = enable && (state == IDLE) && !pipeBusy;

	// The held root is the floor of the square root of the power captured 41 cycles earlier.
	assert property (@(posedge clock) disable iff (reset)
		magnitudeValid |-> (SQ_W'(magnitude) * SQ_W'(magnitude) <= SQ_W'(power))
			&& (SQ_W'(power) < (SQ_W'(magnitude) + 1) * (SQ_W'(magnitude) + 1)))
		else $error("square root out of range");

endmodule

//--- matchedFilter.sv
// ------------------------------------------------------------
// Streaming complex matched filter with an AXI4-Lite register block.
// One sample in flight. Latency is 43 cycles from acceptance to
// magnitudeValid. MF_TAPS must lie between 2 and 16.
// ------------------------------------------------------------
`timescale 1ns/1ps

module matchedFilter #(
	parameter int MF_TAPS = 8
) (
	input  logic clock,
	input  logic reset,
	input  mfPkg::regAddrT awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  mfPkg::regAddrT araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  mfPkg::sampleT sampleIn,
	input  logic sampleValid,
	output logic sampleReady,
	output mfPkg::magnitudeT magnitude,
	output logic magnitudeValid,
	input  logic magnitudeReady
);
	import mfPkg::*;

	logic enable;
	logic clearHistory;
	logic outputFire;
	logic sampleFire;
	logic pipeBusy;
	complexCoeffT coeffs [MF_TAPS];
	analyticSampleT analytic;
	logic analyticValid;
	firOutT firOut;
	logic firValid;

	assign sampleFire = sampleValid && sampleReady;

	// Either early stage still holding a sample blocks new input.
	assign pipeBusy = analyticValid || firValid;

	// Register block, every port name matches a top-level net.
	mfRegs #(
		.MF_TAPS(MF_TAPS)
	) regs (.*);

	hilbertFilter hilbert (
		.clock(clock),
		.reset(reset),
		.clearHistory(clearHistory),
		.sampleIn(sampleIn),
		.sampleFire(sampleFire),
		.analytic(analytic),
		.analyticValid(analyticValid)
	);

	complexFir #(
		.MF_TAPS(MF_TAPS)
	) fir (
		.clock(clock),
		.reset(reset),
		.clearHistory(clearHistory),
		.analytic(analytic),
		.analyticValid(analyticValid),
		.coeffs(coeffs),
		.firOut(firOut),
		.firValid(firValid)
	);

	// The square root stage also owns the input handshake.
	magnitudeSqrt sqrt (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.firOut(firOut),
		.firValid(firValid),
		.pipeBusy(pipeBusy),
		.sampleReady(sampleReady),
		.magnitude(magnitude),
		.magnitudeValid(magnitudeValid),
		.magnitudeReady(magnitudeReady),
		.outputFire(outputFire)
	);

endmodule

//--- tbMatchedFilter.sv
// ------------------------------------------------------------
// Testbench for the matched filter with MF_TAPS at 8.
// Inputs change on the falling edge and outputs are taken on
// the rising edge. Every wait gives up after WAIT_LIMIT cycles.
// ------------------------------------------------------------
`timescale 1ns/1ps

module tbMatchedFilter;
	import mfPkg::*;

	localparam int MF_TAPS = 8;
	localparam int WAIT_LIMIT = 2000;

	logic clock;
	logic reset;
	regAddrT awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	regAddrT araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	sampleT sampleIn;
	logic sampleValid;
	logic sampleReady;
	magnitudeT magnitude;
	logic magnitudeValid;
	// The sink starts out ready and only stalls when back-pressure is on.
	logic magnitudeReady = 1'b1;

	// Reference model state, a mirror of what the DUT should hold.
	sampleT refHilbert [HT_TAPS];
	analyticSampleT refFir [MF_TAPS];
	complexCoeffT refCoeffs [MF_TAPS];
	magnitudeT expectQueue [$];

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testErrors = 0;
	int samplesSent = 0;
	bit timedOut = 0;
	bit randomBackPressure = 0;
	string testName;
	logic [1:0] resp;

	matchedFilter #(
		.MF_TAPS(MF_TAPS)
	) dut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Expected magnitude for one new sample, built from the filter definitions.
	function automatic magnitudeT referenceMagnitude(input sampleT x);
		longint quad;
		longint sumRe;
		longint sumIm;
		analyticSampleT a;
		firOutT f;
		magnitudeT absRe;
		magnitudeT absIm;
		powerT power;
		magnitudeT root;
		magnitudeT trial;
		for (int k = HT_TAPS - 1; k > 0; k--) begin
			refHilbert[k] = refHilbert[k-1];
		end
		refHilbert[0] = x;
		quad = 0;
		for (int k = 0; k < HT_TAPS; k++) begin
			quad += longint'(refHilbert[k]) * longint'(HT_COEFFS[k]);
		end
		a.re = analyticT'(refHilbert[HT_TAPS / 2]);
		a.im = analyticT'(quad >>> HT_SHIFT);
		for (int k = MF_TAPS - 1; k > 0; k--) begin
			refFir[k] = refFir[k-1];
		end
		refFir[0] = a;
		sumRe = 0;
		sumIm = 0;
		for (int k = 0; k < MF_TAPS; k++) begin
			sumRe += longint'(refFir[k].re) * longint'(refCoeffs[k].re)
				- longint'(refFir[k].im) * longint'(refCoeffs[k].im);
			sumIm += longint'(refFir[k].re) * longint'(refCoeffs[k].im)
				+ longint'(refFir[k].im) * longint'(refCoeffs[k].re);
		end
		f.re = firAccT'(sumRe);
		f.im = firAccT'(sumIm);
		absRe = (f.re < 0) ? magnitudeT'(-f.re) : magnitudeT'(f.re);
		absIm = (f.im < 0) ? magnitudeT'(-f.im) : magnitudeT'(f.im);
		power = powerT'(absRe) * powerT'(absRe) + powerT'(absIm) * powerT'(absIm);
		// Floor of the root, found by setting bits from the top down.
		root = '0;
		for (int b = $bits(magnitudeT) - 1; b >= 0; b--) begin
			trial = root | (magnitudeT'(1) << b);
			if (powerT'(trial) * powerT'(trial) <= power) begin
				root = trial;
			end
		end
		return root;
	endfunction

	// A cleared DUT starts both delay lines from zero.
	task automatic clearReference();
		refHilbert = '{default: '0};
		refFir = '{default: '0};
	endtask

	// Each set strobe bit selects one byte of the new word.
	function automatic logic [31:0] applyStrobes(input logic [31:0] oldWord,
		input logic [31:0] newWord, input logic [3:0] strobe);
		logic [31:0] mask;
		mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
		return (oldWord & ~mask) | (newWord & mask);
	endfunction

	function automatic regAddrT coeffAddr(input int tap);
		return regAddrT'(REG_COEFF_BASE + 4 * tap);
	endfunction

	task automatic checkMagnitude(input string name, input magnitudeT actual,
		input magnitudeT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic checkBus(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkResp(input string name, input logic [1:0] actual,
		input logic [1:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, actual, expected);
		end
	endtask

	// One falling edge of waiting. Past the limit it flags the run and all waits end.
	task automatic stepOrTimeout(inout int waited, input string what);
		@(negedge clock);
		waited++;
		if (waited > WAIT_LIMIT) begin
			$display("Timeout at %0t ns while waiting for %s.", $time, what);
			errorCount++;
			timedOut = 1'b1;
		end
	endtask

	// Address and data go out together, as the register block requires.
	task automatic axiWrite(input regAddrT addr, input logic [31:0] data,
		input logic [3:0] strobe, output logic [1:0] result);
		int waited;
		awaddr = addr;
		wdata = data;
		wstrb = strobe;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waited = 0;
		while (!awready && !timedOut) stepOrTimeout(waited, "awready");
		// Both channels are taken on the same edge.
		if (!timedOut && wready !== 1'b1) begin
			errorCount++;
			$display("wready was not raised together with awready at %0t ns.", $time);
		end
		@(negedge clock);
		awvalid = 1'b0;
		wvalid = 1'b0;
		waited = 0;
		while (!bvalid && !timedOut) stepOrTimeout(waited, "bvalid");
		result = bresp;
		@(negedge clock);
	endtask

	task automatic axiRead(input regAddrT addr, output logic [31:0] data,
		output logic [1:0] result);
		int waited;
		araddr = addr;
		arvalid = 1'b1;
		waited = 0;
		while (!arready && !timedOut) stepOrTimeout(waited, "arready");
		@(negedge clock);
		arvalid = 1'b0;
		waited = 0;
		while (!rvalid && !timedOut) stepOrTimeout(waited, "rvalid");
		data = rdata;
		result = rresp;
		@(negedge clock);
	endtask

	task automatic readExpect(input regAddrT addr, input logic [31:0] expected);
		logic [31:0] data;
		logic [1:0] result;
		axiRead(addr, data, result);
		checkBus("rdata", data, expected);
		checkResp("rresp", result, RESP_OKAY);
	endtask

	task automatic writeCoeff(input int tap, input logic [31:0] data, input logic [3:0] strobe);
		logic [1:0] result;
		axiWrite(coeffAddr(tap), data, strobe, result);
		checkResp("bresp", result, RESP_OKAY);
		refCoeffs[tap] = applyStrobes(refCoeffs[tap], data, strobe);
	endtask

	task automatic writeControl(input logic [31:0] value);
		logic [1:0] result;
		axiWrite(REG_CONTROL, value, 4'hF, result);
		checkResp("bresp", result, RESP_OKAY);
		if (value[CTRL_CLEAR_BIT]) begin
			clearReference();
		end
	endtask

	// The expected value is queued before the edge that takes the sample.
	task automatic sendSample(input sampleT x);
		int waited;
		sampleIn = x;
		sampleValid = 1'b1;
		waited = 0;
		while (!sampleReady && !timedOut) stepOrTimeout(waited, "sampleReady");
		if (!timedOut) begin
			expectQueue.push_back(referenceMagnitude(x));
			samplesSent++;
		end
		@(negedge clock);
		sampleValid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expectQueue.size() != 0 && !timedOut) stepOrTimeout(waited, "outstanding results");
	endtask

	// The first two samples of every four sit at positive and negative full scale.
	function automatic sampleT edgeSample(input int i);
		if (i % 4 == 0) begin
			return 16'sh7FFF;
		end else if (i % 4 == 1) begin
			return 16'sh8000;
		end
		return sampleT'($urandom);
	endfunction

	task automatic beginTest(input string name);
		testName = name;
		testErrors = errorCount;
		testCount++;
	endtask

	task automatic endTest();
		$display("Test %0d (%s): %s", testCount, testName,
			(errorCount == testErrors) ? "ok" : "failed");
	endtask

	// Back-pressure, when on, drops ready on about half the cycles.
	always @(negedge clock) begin
		magnitudeReady = randomBackPressure ? 1'($urandom_range(0, 1)) : 1'b1;
	end

	// Monitor for every result that the sink takes.
	always @(posedge clock) begin
		if (!reset) begin
			if (magnitudeValid && sampleValid && sampleReady) begin
				errorCount++;
				$display("A sample was accepted while a result was held at %0t ns.", $time);
			end
			if (magnitudeValid && magnitudeReady) begin
				if (expectQueue.size() == 0) begin
					errorCount++;
					$display("A magnitude came out with none expected at %0t ns.", $time);
				end else begin
					checkMagnitude("magnitude", magnitude, expectQueue.pop_front());
				end
			end
		end
	end

	initial begin
		logic [31:0] data;
		void'($urandom(57228));
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		sampleIn = '0;
		sampleValid = 1'b0;
		refCoeffs = '{default: '0};
		clearReference();
		// Two rising edges under reset, then release on a falling edge.
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		beginTest("reset state and coefficient access");
		if (sampleReady || magnitudeValid) begin
			errorCount++;
			$display("sampleReady or magnitudeValid is high after reset.");
		end
		readExpect(REG_STATUS, 32'h0);
		for (int k = 0; k < MF_TAPS; k++) readExpect(coeffAddr(k), 32'h0);
		for (int k = 0; k < MF_TAPS; k++) writeCoeff(k, $urandom, 4'hF);
		writeCoeff(0, $urandom, 4'b0101);
		writeCoeff(1, $urandom, 4'b1000);
		writeCoeff(2, $urandom, 4'b0000);
		for (int k = 0; k < MF_TAPS; k++) readExpect(coeffAddr(k), refCoeffs[k]);
		endTest();

		beginTest("single tap response");
		for (int k = 0; k < MF_TAPS; k++) writeCoeff(k, (k == 0) ? 32'h0000_7FFF : 32'h0, 4'hF);
		writeControl(32'h1);
		repeat (20) sendSample(sampleT'($urandom));
		drain();
		readExpect(REG_STATUS, {16'(samplesSent), 15'b0, 1'b1});
		endTest();

		beginTest("random complex response");
		for (int k = 0; k < MF_TAPS; k++) writeCoeff(k, $urandom, 4'hF);
		for (int i = 0; i < 24; i++) sendSample(edgeSample(i));
		drain();
		endTest();

		beginTest("output back-pressure");
		randomBackPressure = 1'b1;
		for (int i = 0; i < 16; i++) sendSample(edgeSample(i + 2));
		drain();
		randomBackPressure = 1'b0;
		@(negedge clock);
		endTest();

		beginTest("bad addresses");
		axiWrite(coeffAddr(MF_TAPS), $urandom, 4'hF, resp);
		checkResp("bresp", resp, RESP_SLVERR);
		axiWrite(8'h08, $urandom, 4'hF, resp);
		checkResp("bresp", resp, RESP_SLVERR);
		axiWrite(8'hFC, $urandom, 4'hF, resp);
		checkResp("bresp", resp, RESP_SLVERR);
		axiRead(8'h3C, data, resp);
		checkResp("rresp", resp, RESP_SLVERR);
		for (int k = 0; k < MF_TAPS; k++) readExpect(coeffAddr(k), refCoeffs[k]);
		endTest();

		beginTest("history clear and disable");
		writeControl(32'h3);
		for (int i = 0; i < 12; i++) sendSample(edgeSample(i + 1));
		drain();
		writeControl(32'h0);
		sampleIn = sampleT'($urandom);
		sampleValid = 1'b1;
		repeat (20) begin
			@(negedge clock);
			if (sampleReady) begin
				errorCount++;
				$display("sampleReady went high while the filter was disabled at %0t ns.", $time);
			end
		end
		sampleValid = 1'b0;
		endTest();

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0 && !timedOut) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
mfPkg.sv
mfRegs.sv
hilbertFilter.sv
complexFir.sv
magnitudeSqrt.sv
matchedFilter.sv
tbMatchedFilter.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the matched filter testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbMatchedFilter -f src.f
./obj_dir/VtbMatchedFilter 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation reported a failure."
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "Simulation ended without a result line."
	exit 1
fi
echo "Simulation passed."
